// File: hw/hp_rom_chip.sv
/*
 * HP-35 ROM chip top level
 * sync counter, output enable, instruction path and word select
 */
`timescale 1ns/1ps

module hp_rom_chip #(
    // place in the address space, 0 powers up owning the bus
    parameter int unsigned ROM_NUMBER = 0
) (
    input  logic PHI2,
    input  logic reset,
    input  logic sync,
    input  logic ia,
    input  logic is_in,
    output logic is_out,
    output logic is_active,
    output logic ws_out,
    output logic ws_active
);
    import hp_rom_pkg::*;

    // bit-time strobes shared by every block
    bit_strobes_t strobes;
    // current instruction register contents
    instr_t       instr;
    // serial bit as it leaves the instruction register
    logic         is_bit;

    word_sync_counter u_sync (
        .PHI2    (PHI2),
        .reset   (reset),
        .sync    (sync),
        .strobes (strobes)
    );

    rom_output_enable #(
        .ROM_NUMBER (ROM_NUMBER)
    ) u_roe (
        .PHI2    (PHI2),
        .reset   (reset),
        .strobes (strobes),
        .instr   (instr),
        .active  (is_active)
    );

    instruction_path u_ipath (
        .PHI2    (PHI2),
        .reset   (reset),
        .strobes (strobes),
        .active  (is_active),
        .sync    (sync),
        .ia      (ia),
        .is_in   (is_in),
        .instr   (instr),
        .is_bit  (is_bit),
        .is_out  (is_out)
    );

    word_select_gen u_ws (
        .PHI2      (PHI2),
        .reset     (reset),
        .strobes   (strobes),
        .active    (is_active),
        .is_bit    (is_bit),
        .ws_out    (ws_out),
        .ws_active (ws_active)
    );

endmodule

// File: hw/hp_rom_pkg.sv
/*
 * shared definitions for the HP-35 ROM chip
 *   word-cycle length and named bit times
 *   instruction, address and ROM SELECT encodings
 *   word-select codes, output-enable states, bit-time strobes
 */
package hp_rom_pkg;

    // ----------------------------
    // word cycle
    // ----------------------------

    // bit times per word cycle, b0 to b55
    localparam int WORD_BITS    = 56;
    // counter wide enough for every bit time
    localparam int BIT_CNT_BITS = $clog2(WORD_BITS);

    // exponent minus-sign pulse on the instruction line
    localparam int BT_EXP_SIGN   = 11;
    // serial address window, b19 up to but not including b27
    localparam int BT_ADDR_OPEN  = 19;
    localparam int BT_ADDR_CLOSE = 27;
    // addressed word clocks into the instruction register
    localparam int BT_LOAD       = 43;
    // word-select master and slave capture points
    localparam int BT_WS_SAMPLE  = 50;
    localparam int BT_WS_LATCH   = 54;

    // ----------------------------
    // instruction word
    // ----------------------------

    localparam int ADDR_BITS  = 8;
    localparam int INSTR_BITS = 10;

    // low seven bits of a ROM SELECT, chip number sits in the top three
    localparam logic [6:0] ROM_SELECT_OP = 7'b0010000;

    // sparse binary image, words not listed read as zero
    localparam string ROM_IMAGE_FILE = "hw/rom_image.mem";

    typedef logic [INSTR_BITS-1:0] instr_t;
    typedef logic [ADDR_BITS-1:0]  rom_addr_t;

    // field codes the ROM generates itself
    // 000 and 100 are pointer fields owned by the control chip
    typedef enum logic [2:0] {
        WS_M  = 3'b001,     // mantissa, digits 3-12
        WS_X  = 3'b010,     // exponent, digits 0-2
        WS_W  = 3'b011,     // whole word, digits 0-13
        WS_MS = 3'b101,     // mantissa and sign, digits 3-13
        WS_XS = 3'b110,     // exponent sign, digit 2
        WS_S  = 3'b111      // mantissa sign, digit 13
    } ws_code_e;

    // output enable, releasing keeps the bus until b55
    typedef enum logic [1:0] {
        ROE_IDLE      = 2'b00,
        ROE_ACTIVE    = 2'b01,
        ROE_RELEASING = 2'b10
    } roe_state_e;

    // ----------------------------
    // decoded bit times
    // ----------------------------

    // single-cycle strobes are high during the named bit time
    // digit flags look one bit ahead, digit names the coming bit's digit
    typedef struct packed {
        logic       b11;
        logic       b43;
        logic       b44;
        logic       b50;
        logic       b54;
        logic       b55;
        logic       addr_open;
        logic       digit_first;
        logic       digit_last;
        logic [3:0] digit;
    } bit_strobes_t;

endpackage

// File: hw/instruction_path.sv
/*
 * serial address register fed from ia
 * 256-word ROM array loaded from the image file
 * shifting instruction register and is_out driver
 */
`timescale 1ns/1ps

module instruction_path (
    input  logic                     PHI2,
    input  logic                     reset,
    input  hp_rom_pkg::bit_strobes_t strobes,
    input  logic                     active,
    input  logic                     sync,
    input  logic                     ia,
    input  logic                     is_in,
    output hp_rom_pkg::instr_t       instr,
    output logic                     is_bit,
    output logic                     is_out
);
    import hp_rom_pkg::*;

    rom_addr_t addr_reg;
    instr_t    rom_mem [0:(1 << ADDR_BITS) - 1];
    instr_t    instr_reg;
    logic      is_gated;

    // ----------------------------
    // ROM contents
    // ----------------------------
    initial begin
        // image is sparse, so clear first
        for (int i = 0; i < (1 << ADDR_BITS); i++) begin
            rom_mem[i] = '0;
        end
        $readmemb(ROM_IMAGE_FILE, rom_mem);
    end

    // ----------------------------
    // address register
    // ----------------------------
    always_ff @(posedge PHI2) begin
        // lsb arrives first, ends up at bit 0 after eight shifts
        if (strobes.addr_open) begin
            addr_reg <= {ia, addr_reg[ADDR_BITS-1:1]};
        end
    end

    // own output must not echo back in while driving the bus
    assign is_gated = is_in & ~active;

    // ----------------------------
    // instruction register
    // ----------------------------
    always_ff @(posedge PHI2) begin
        if (reset) begin
            instr_reg <= '0;
        end else if (strobes.b43 && active) begin
            // word ready in b44, first bit on the line in b45
            instr_reg <= rom_mem[addr_reg];
        end else if (sync) begin
            // active chip shifts its word out
            // inactive chip collects the word from the bus
            instr_reg <= {is_gated, instr_reg[INSTR_BITS-1:1]};
        end
    end

    assign instr  = instr_reg;
    assign is_bit = instr_reg[0];

    // serial word during SYNC plus the exponent-sign marker at b11
    assign is_out = (sync & instr_reg[0]) | strobes.b11;

endmodule

// File: hw/rom_image.mem
// sparse ROM image, one 10-bit instruction word per line in binary
// @hh sets the hex address of the next word, unlisted words read as zero
@00
0000000000
// plain words with no word-select request
@05
1011001101
@1A
0110110001
@3C
1100011100
@77
1111111111
@A5
0101010101
@FE
1110001011
// type-2 arithmetic, fields M, X and W
@40
1010100110
@41
0110001010
@42
0001101110
// ROM SELECT handing the bus to ROM 1
@F0
0010010000

// File: hw/rom_output_enable.sv
/*
 * ROM output enable FSM
 * ROM SELECT release at b44/b55 and take-over at b55
 */
`timescale 1ns/1ps

module rom_output_enable #(
    parameter int unsigned ROM_NUMBER = 0
) (
    input  logic                     PHI2,
    input  logic                     reset,
    input  hp_rom_pkg::bit_strobes_t strobes,
    input  hp_rom_pkg::instr_t       instr,
    output logic                     active
);
    import hp_rom_pkg::*;

    roe_state_e state;
    roe_state_e state_next;
    logic       rom_select;
    logic       this_rom;

    // ROM SELECT pattern in the low field
    assign rom_select = (instr[$bits(ROM_SELECT_OP)-1:0] == ROM_SELECT_OP);
    // chip number carried in the top three bits
    assign this_rom = (instr[INSTR_BITS-1:$bits(ROM_SELECT_OP)] == 3'(ROM_NUMBER));

    // ----------------------------
    // next state
    // ----------------------------
    always_comb begin
        state_next = state;
        unique case (state)
            ROE_ACTIVE: begin
                // fetched word sits in the register during b44
                // any ROM SELECT drops this chip at the end of the cycle
                if (strobes.b44 && rom_select) begin
                    state_next = ROE_RELEASING;
                end
            end
            ROE_RELEASING: begin
                // still drives the select word out over b45-b54
                if (strobes.b55) begin
                    state_next = ROE_IDLE;
                end
            end
            ROE_IDLE: begin
                // word shifted in from the bus is complete at b55
                if (strobes.b55 && rom_select && this_rom) begin
                    state_next = ROE_ACTIVE;
                end
            end
            default: begin
                state_next = ROE_IDLE;
            end
        endcase
    end

    // ----------------------------
    // state register
    // ----------------------------
    always_ff @(posedge PHI2) begin
        if (reset) begin
            // only ROM 0 owns the bus after power on
            state <= (ROM_NUMBER == 0) ? ROE_ACTIVE : ROE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // releasing chip keeps the bus until the word cycle ends
    assign active = (state == ROE_ACTIVE) || (state == ROE_RELEASING);

endmodule

// File: hw/word_select_gen.sv
/*
 * word-select register, master at b50 and slave at b54
 * digit-window decoder driving ws_out over the next word cycle
 */
`timescale 1ns/1ps

module word_select_gen (
    input  logic                     PHI2,
    input  logic                     reset,
    input  hp_rom_pkg::bit_strobes_t strobes,
    input  logic                     active,
    input  logic                     is_bit,
    output logic                     ws_out,
    output logic                     ws_active
);
    import hp_rom_pkg::*;

    // newest bit in [0], first instruction bit reaches [4] at b50
    logic [4:0] is_shift;
    ws_code_e   code_sample;
    logic       req_sample;
    ws_code_e   ws_code_m;
    logic       ws_req_m;
    ws_code_e   ws_code_s;
    logic       ws_req_s;
    logic       ws_oe;
    logic [3:0] ws_begin;
    logic [3:0] ws_end;
    logic       set_ws;
    logic       clr_ws_pre;
    logic       clr_ws;

    // ----------------------------
    // sampler and master/slave
    // ----------------------------

    // code order matches the encoding table, bit 4 on the left
    assign code_sample = ws_code_e'({is_shift[0], is_shift[1], is_shift[2]});

    // type-2 arithmetic opens with 0 then 1
    // pointer fields stay with the control chip
    assign req_sample = ~is_shift[4] & is_shift[3] &
                        (code_sample inside {WS_X, WS_XS, WS_M, WS_MS, WS_W, WS_S});

    always_ff @(posedge PHI2) begin
        is_shift <= {is_shift[3:0], is_bit};
        // code fields hold data only, request flags carry control
        if (strobes.b50) begin
            ws_code_m <= code_sample;
        end
        if (strobes.b54) begin
            ws_code_s <= ws_code_m;
        end
    end

    always_ff @(posedge PHI2) begin
        if (reset) begin
            ws_req_m <= 1'b0;
            ws_req_s <= 1'b0;
            ws_oe    <= 1'b0;
        end else begin
            if (strobes.b50) begin
                ws_req_m <= req_sample;
            end
            if (strobes.b54) begin
                ws_req_s <= ws_req_m;
            end
            // one bit later lines up with b0 to b55
            ws_oe <= ws_req_s;
        end
    end

    // ----------------------------
    // digit window decode
    // ----------------------------
    always_comb begin
        unique case (ws_code_s)
            WS_X:    begin ws_begin = 4'd0;  ws_end = 4'd2;  end
            WS_XS:   begin ws_begin = 4'd2;  ws_end = 4'd2;  end
            WS_M:    begin ws_begin = 4'd3;  ws_end = 4'd12; end
            WS_MS:   begin ws_begin = 4'd3;  ws_end = 4'd13; end
            WS_W:    begin ws_begin = 4'd0;  ws_end = 4'd13; end
            WS_S:    begin ws_begin = 4'd13; ws_end = 4'd13; end
            // digit 15 never comes up, window stays shut
            default: begin ws_begin = 4'd15; ws_end = 4'd15; end
        endcase
    end

    // flags lead by a bit, so the register edge hits the digit start
    assign set_ws     = strobes.digit_first && (strobes.digit == ws_begin);
    assign clr_ws_pre = strobes.digit_last && (strobes.digit == ws_end);

    always_ff @(posedge PHI2) begin
        if (reset) begin
            clr_ws <= 1'b0;
            ws_out <= 1'b0;
        end else begin
            // delayed clear holds ws_out through the last bit of the end digit
            clr_ws <= clr_ws_pre;
            if (set_ws) begin
                ws_out <= 1'b1;
            end else if (clr_ws) begin
                ws_out <= 1'b0;
            end
        end
    end

    // only the chip owning the bus drives the select window
    assign ws_active = active & ws_oe;

endmodule

// File: hw/word_sync_counter.sv
/*
 * 56-state bit-time counter locked to the falling edge of SYNC
 * registered bit-time strobes and digit boundary flags
 */
`timescale 1ns/1ps

module word_sync_counter (
    input  logic                     PHI2,
    input  logic                     reset,
    input  logic                     sync,
    output hp_rom_pkg::bit_strobes_t strobes
);
    import hp_rom_pkg::*;

    logic                    sync_q;
    logic                    sync_fall;
    // bit time of the coming cycle, not the current one
    logic [BIT_CNT_BITS-1:0] cnt;
    logic [BIT_CNT_BITS-1:0] cnt_next;

    // sync low now but high last bit means this is b55
    assign sync_fall = sync_q & ~sync;

    // ----------------------------
    // counter next state
    // ----------------------------
    always_comb begin
        if (sync_fall) begin
            // b0 follows, so the counter already names b1
            cnt_next = BIT_CNT_BITS'(1);
        end else if (cnt == BIT_CNT_BITS'(WORD_BITS - 1)) begin
            cnt_next = '0;
        end else begin
            cnt_next = cnt + 1'b1;
        end
    end

    // ----------------------------
    // counter and strobes
    // ----------------------------
    always_ff @(posedge PHI2) begin
        if (reset) begin
            sync_q  <= 1'b0;
            cnt     <= '0;
            strobes <= '0;
        end else begin
            sync_q <= sync;
            cnt    <= cnt_next;

            // decode from cnt lands the strobe on the named bit
            strobes.b11 <= (cnt == BIT_CNT_BITS'(BT_EXP_SIGN));
            strobes.b43 <= (cnt == BIT_CNT_BITS'(BT_LOAD));
            strobes.b50 <= (cnt == BIT_CNT_BITS'(BT_WS_SAMPLE));
            strobes.b54 <= (cnt == BIT_CNT_BITS'(BT_WS_LATCH));
            // one bit after their neighbours
            strobes.b44 <= strobes.b43;
            strobes.b55 <= strobes.b54;

            // address window covers b19 through b26
            if (cnt == BIT_CNT_BITS'(BT_ADDR_OPEN)) begin
                strobes.addr_open <= 1'b1;
            end else if (cnt == BIT_CNT_BITS'(BT_ADDR_CLOSE)) begin
                strobes.addr_open <= 1'b0;
            end

            // decode from cnt_next so flags lead the digit by one bit
            strobes.digit_first <= (cnt_next[1:0] == 2'b00);
            strobes.digit_last  <= (cnt_next[1:0] == 2'b11);
            strobes.digit       <= cnt_next[BIT_CNT_BITS-1:2];
        end
    end

endmodule

// File: project.f
hw/hp_rom_pkg.sv
hw/word_sync_counter.sv
hw/rom_output_enable.sv
hw/instruction_path.sv
hw/word_select_gen.sv
hw/hp_rom_chip.sv
verif/tb_hp_rom_chip.sv

// File: verif/tb_hp_rom_chip.sv
/*
 * testbench for the HP-35 ROM chip, ROM 0
 * word-cycle stimulus on sync, ia and is_in
 * reference model from the ROM image and concurrent assertions
 */
`timescale 1ns/1ps

module tb_hp_rom_chip;

    localparam int          CYCLE_LIMIT = 40 * 56 + 100;
    localparam string       IMAGE_PATH  = "hw/rom_image.mem";
    localparam logic [6:0]  SELECT_LOW  = 7'b0010000;

    logic PHI2;
    logic reset;
    logic sync;
    logic ia;
    logic is_in;
    logic is_out;
    logic is_active;
    logic ws_out;
    logic ws_active;

    // reference model state
    logic [9:0] model_rom [0:255];
    logic       exp_act;
    logic       ws_prev;
    logic [2:0] ws_prev_code;

    // expected values and check enables for the current bit time
    logic chk_reset;
    logic chk_is_out;
    logic exp_is_out;
    logic chk_active;
    logic exp_is_active;
    logic chk_ws;
    logic exp_ws_active;
    logic chk_ws_out;
    logic exp_ws_out;

    int error_count;
    int cycle_count;
    int word_count;

    // listed words that keep the bus with ROM 0
    logic [7:0] fetch_addrs [9] = '{8'h05, 8'h1A, 8'h3C, 8'h77, 8'hA5,
                                    8'hFE, 8'h40, 8'h41, 8'h42};

    hp_rom_chip #(
        .ROM_NUMBER (0)
    ) UUT (
        .PHI2      (PHI2),
        .reset     (reset),
        .sync      (sync),
        .ia        (ia),
        .is_in     (is_in),
        .is_out    (is_out),
        .is_active (is_active),
        .ws_out    (ws_out),
        .ws_active (ws_active)
    );

    initial begin
        PHI2 = 1'b0;
        forever #50 PHI2 = ~PHI2;
    end

    // ------------------------------
    // reference rules
    // ------------------------------
    function automatic logic is_select(input logic [9:0] w);
        return w[6:0] == SELECT_LOW;
    endfunction

    // type-2 arithmetic opens with 0 then 1
    // pointer codes 000 and 100 stay with the control chip
    function automatic logic ws_request(input logic [9:0] w);
        return !w[0] && w[1] && (w[4:2] != 3'b000) && (w[4:2] != 3'b100);
    endfunction

    task automatic field_digits(input logic [2:0] code, output int first, output int last);
        case (code)
            3'b010:  begin first = 0;  last = 2;  end
            3'b110:  begin first = 2;  last = 2;  end
            3'b001:  begin first = 3;  last = 12; end
            3'b101:  begin first = 3;  last = 13; end
            3'b011:  begin first = 0;  last = 13; end
            3'b111:  begin first = 13; last = 13; end
            default: begin first = 99; last = 99; end
        endcase
    endtask

    // ------------------------------
    // one word cycle from b0 to b55
    // ------------------------------
    task automatic play_word_cycle(input logic [7:0] addr, input logic [9:0] bus_word,
                                   input logic checked);
        logic [9:0] word;
        logic       loaded;
        logic       next_act;
        int         first_d;
        int         last_d;
        word     = model_rom[addr];
        // only a chip owning the bus at b43 fetches its word
        loaded   = exp_act;
        next_act = exp_act;
        field_digits(ws_prev_code, first_d, last_d);
        for (int k = 0; k < 56; k++) begin
            @(posedge PHI2);
            sync  <= (k >= 45) && (k <= 54);
            ia    <= ((k >= 19) && (k <= 26)) ? addr[k-19] : 1'b0;
            is_in <= ((k >= 45) && (k <= 54)) ? bus_word[k-45] : 1'b0;
            chk_reset <= 1'b0;

            chk_active    <= checked;
            exp_is_active <= exp_act;

            if (k == 11) begin
                chk_is_out <= checked;
                exp_is_out <= 1'b1;
            end else if ((k >= 45) && (k <= 54)) begin
                // bus residue of an idle chip goes unchecked
                chk_is_out <= checked && loaded;
                exp_is_out <= word[k-45];
            end else begin
                chk_is_out <= checked;
                exp_is_out <= 1'b0;
            end

            chk_ws        <= checked;
            exp_ws_active <= ws_prev && exp_act;
            chk_ws_out    <= checked && ws_prev && exp_act;
            exp_ws_out    <= (k >= 4 * first_d) && (k <= 4 * last_d + 3);
        end
        // hand-over takes effect from the next b0
        if (loaded && is_select(word)) begin
            next_act = 1'b0;
        end
        if (!exp_act && is_select(bus_word) && (bus_word[9:7] == 3'd0)) begin
            next_act = 1'b1;
        end
        ws_prev      = loaded && ws_request(word);
        ws_prev_code = word[4:2];
        exp_act      = next_act;
        word_count++;
    endtask

    // ------------------------------
    // checks
    // ------------------------------
    a_reset_state: assert property (@(negedge PHI2)
        chk_reset |-> (is_active && !ws_out && !ws_active))
        else begin
            error_count++;
            $display("Error at %0t: state after reset is_active %b ws_out %b ws_active %b",
                     $time, is_active, ws_out, ws_active);
        end

    // serial word and the b11 exponent-sign pulse
    a_is_out: assert property (@(negedge PHI2) chk_is_out |-> (is_out == exp_is_out))
        else begin
            error_count++;
            $display("Error at %0t: is_out %b, expected %b", $time, is_out, exp_is_out);
        end

    a_is_active: assert property (@(negedge PHI2) chk_active |-> (is_active == exp_is_active))
        else begin
            error_count++;
            $display("Error at %0t: is_active %b, expected %b", $time, is_active, exp_is_active);
        end

    a_ws_active: assert property (@(negedge PHI2) chk_ws |-> (ws_active == exp_ws_active))
        else begin
            error_count++;
            $display("Error at %0t: ws_active %b, expected %b", $time, ws_active, exp_ws_active);
        end

    a_ws_out: assert property (@(negedge PHI2) chk_ws_out |-> (ws_out == exp_ws_out))
        else begin
            error_count++;
            $display("Error at %0t: ws_out %b, expected %b", $time, ws_out, exp_ws_out);
        end

    // ------------------------------
    // run limit
    // ------------------------------
    always @(posedge PHI2) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        sync  = 1'b0;
        ia    = 1'b0;
        is_in = 1'b0;
        chk_reset  = 1'b0;
        chk_is_out = 1'b0;
        exp_is_out = 1'b0;
        chk_active = 1'b0;
        exp_is_active = 1'b0;
        chk_ws        = 1'b0;
        exp_ws_active = 1'b0;
        chk_ws_out    = 1'b0;
        exp_ws_out    = 1'b0;
        error_count = 0;
        cycle_count = 0;
        word_count  = 0;
        void'($urandom(13251));

        for (int i = 0; i < 256; i++) begin
            model_rom[i] = '0;
        end
        $readmemb(IMAGE_PATH, model_rom);

        // ROM 0 owns the bus after power on
        exp_act      = 1'b1;
        ws_prev      = 1'b0;
        ws_prev_code = 3'b000;

        repeat (4) @(posedge PHI2);
        reset <= 1'b0;
        @(posedge PHI2);
        chk_reset <= 1'b1;

        // first SYNC fall locks the counter
        play_word_cycle(8'h00, 10'd0, 1'b0);

        // random fetches with noise on is_in
        for (int n = 0; n < 8; n++) begin
            play_word_cycle(fetch_addrs[$urandom % 9], 10'($urandom), 1'b1);
        end

        // word-select fields M, X, W back to back
        play_word_cycle(8'h40, 10'd0, 1'b1);
        play_word_cycle(8'h41, 10'd0, 1'b1);
        play_word_cycle(8'h42, 10'd0, 1'b1);
        play_word_cycle(8'h05, 10'd0, 1'b1);

        // hand the bus to ROM 1 and send a select for ROM 2 that has no effect
        play_word_cycle(8'hF0, 10'd0, 1'b1);
        play_word_cycle(8'h00, {3'd2, SELECT_LOW}, 1'b1);
        // select for ROM 0 from the bus takes it back
        play_word_cycle(8'h00, {3'd0, SELECT_LOW}, 1'b1);
        play_word_cycle(8'h1A, 10'd0, 1'b1);
        play_word_cycle(8'h40, 10'd0, 1'b1);
        play_word_cycle(8'hA5, 10'd0, 1'b1);

        @(posedge PHI2);
        chk_is_out <= 1'b0;
        chk_active <= 1'b0;
        chk_ws     <= 1'b0;
        chk_ws_out <= 1'b0;
        @(posedge PHI2);

        $display("word cycles: %0d, clock cycles: %0d, errors: %0d",
                 word_count, cycle_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
